// ==== files.f ====
verilog/sos_audio_pkg.sv
verilog/sos_ctrl_pkg.sv
verilog/impulse_generator.sv
verilog/window_energy.sv
verilog/echo_timer.sv
verilog/ranging_fsm.sv
verilog/sos_ranger.sv
sim/sos_ranger_tb.sv

// ==== sim/sos_ranger_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module sos_ranger_tb;

	import sos_audio_pkg::*;
	import sos_ctrl_pkg::*;

	localparam int WINDOW = 16;
	localparam int MAX_STEPS = 256;
	localparam int HOLDOFF = 200;
	localparam int PING_STEPS = 8;
	localparam amp_t PING_AMP = 16'sd12000;
	localparam int ECHO_LEN = 16;     // echo lasts this many steps
	localparam int AGREE = 3;
	localparam int SILENT_PINGS = 6;
	localparam int WAIT_LIMIT = 12000; // clocks per wait
	localparam int NUM_ROWS = 5;
	localparam longint SUM_ONES = 24'hff_ffff; // past sums after a clear

	typedef struct packed {
		logic [11:0] echo_step;
		logic [7:0] echo_amp;
		logic [4:0][7:0] offset; // [i] shifts the echo of attempt i+1
		logic [3:0] pings;       // pings until agreement, 0 for a silent row
	} row_t;

	logic clk_in = 1'b0;
	logic rst_in;
	logic step_in;
	logic trigger;
	sample_t mic_in;
	amp_t amp_out;
	delay_t delay;
	logic delay_valid;
	logic busy;

	row_t rows [NUM_ROWS];
	row_t cur;
	logic [15:0] lfsr;
	int last_noise;
	int phase;
	int step_idx;     // steps since the last ping ended
	logic counting;
	logic amp_was_high;
	int high_steps;
	int ping_count;
	int echo_start;
	logic ref_active;
	int ref_n;
	longint ref_sum;
	longint ref_prev;
	longint ref_prev2;
	int ref_hist [$];
	int ref_attempts;
	int agree_ping;
	int agree_delay;

	sos_ranger #(
		.WINDOW_SIZE(WINDOW),
		.MAX_DELAY(MAX_STEPS),
		.HOLDOFF_CYCLES(HOLDOFF),
		.PULSE_AMP(PING_AMP),
		.PULSE_STEPS(PING_STEPS)
	) sos_ranger_inst (
		.clk_in(clk_in),
		.rst_in(rst_in),
		.step_in(step_in),
		.trigger(trigger),
		.mic_in(mic_in),
		.amp_out(amp_out),
		.delay(delay),
		.delay_valid(delay_valid),
		.busy(busy)
	);

	always #5 clk_in = ~clk_in;

	task automatic fail_run(string msg);
		$display("%s", msg);
		$display("Test failures found");
		$fatal(1);
	endtask

	task automatic check_value(string name, logic [31:0] got, logic [31:0] expected);
		if (got !== expected)
			fail_run($sformatf("error: %s got 0x%0h expected 0x%0h", name, got, expected));
	endtask

	// x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic noise_bit();
		logic fb;
		fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
		lfsr = {lfsr[14:0], fb};
		return fb;
	endfunction

	// each step pair sums to 3, so every window holds the same noise energy
	function automatic sample_t noise_sample(int idx);
		int mag;
		if (idx % 2 == 1) begin
			last_noise = {noise_bit(), noise_bit()};
			return sample_t'(last_noise);
		end
		mag = 3 - last_noise;
		return -sample_t'(mag); // negative half exercises the abs
	endfunction

	function automatic sample_t mic_sample(int idx);
		if (cur.echo_amp != 0 && idx >= echo_start && idx < echo_start + ECHO_LEN)
			return sample_t'(cur.echo_amp);
		return noise_sample(idx);
	endfunction

	task automatic record_attempt(int d);
		logic same;
		ref_attempts++;
		if (d < 0) begin
			ref_hist.delete(); // a miss breaks the run
		end else begin
			ref_hist.push_back(d);
			if (ref_hist.size() > AGREE)
				void'(ref_hist.pop_front());
			same = (ref_hist.size() == AGREE);
			foreach (ref_hist[i])
				if (ref_hist[i] != d)
					same = 1'b0;
			if (same && agree_ping == 0) begin
				agree_ping = ping_count;
				agree_delay = d;
			end
		end
	endtask

	task automatic reference_step(sample_t s);
		int mag;
		mag = (s < 0) ? -int'(s) : int'(s);
		ref_sum += mag;
		ref_n++;
		if (ref_n % WINDOW == 0) begin
			// louder than the last window and more than 1.25x the one before
			if (ref_sum > ref_prev && 4 * ref_sum > 5 * ref_prev2) begin
				ref_active = 1'b0;
				record_attempt(ref_n);
			end else begin
				ref_prev2 = ref_prev;
				ref_prev = ref_sum;
				ref_sum = 0;
			end
		end
		if (ref_active && ref_n == MAX_STEPS) begin
			ref_active = 1'b0;
			record_attempt(-1);
		end
	endtask

	// one clock, observe at the falling edge and then drive
	task automatic tick();
		sample_t s;
		@(negedge clk_in);
		trigger = 1'b0;
		if (amp_out != 0) begin
			check_value("amp_out", amp_out, PING_AMP);
			amp_was_high = 1'b1;
		end else if (amp_was_high) begin
			check_value("ping_steps", high_steps, PING_STEPS);
			amp_was_high = 1'b0;
			high_steps = 0;
			ping_count++;
			step_idx = 0;
			counting = 1'b1;
			echo_start = cur.echo_step + cur.offset[(ping_count > 5) ? 4 : ping_count - 1];
			ref_active = 1'b1;
			ref_n = 0;
			ref_sum = 0;
			ref_prev = SUM_ONES;
			ref_prev2 = SUM_ONES;
		end
		phase = (phase + 1) % 4;
		step_in = (phase == 0);
		if (step_in) begin
			if (amp_out != 0)
				high_steps++;
			if (counting) begin
				step_idx++;
				s = mic_sample(step_idx);
				mic_in = s;
				if (ref_active)
					reference_step(s);
			end
		end
	endtask

	task automatic apply_reset();
		rst_in = 1'b1;
		repeat (5) tick();
		rst_in = 1'b0;
		amp_was_high = 1'b0;
		counting = 1'b0;
		high_steps = 0;
		ref_active = 1'b0;
		tick();
		check_value("amp_out", amp_out, 0);
		check_value("delay_valid", delay_valid, 0);
		check_value("busy", busy, 0);
		check_value("delay", delay, 0);
	endtask

	task automatic start_measurement(int r);
		cur = rows[r];
		ping_count = 0;
		ref_hist.delete();
		ref_attempts = 0;
		agree_ping = 0;
		agree_delay = 0;
		check_value("busy", busy, 0);
		trigger = 1'b1;
		tick();
		check_value("busy", busy, 1); // FIRE clock
		check_value("delay_valid", delay_valid, 0);
	endtask

	initial begin
		int waited;
		logic [31:0] held;
		rst_in = 1'b1;
		trigger = 1'b0;
		step_in = 1'b0;
		mic_in = '0;
		lfsr = 16'd57;
		last_noise = 0;
		phase = 0;
		step_idx = 0;
		ping_count = 0;
		echo_start = 0;
		cur = '0;
		rows[0] = '{echo_step: 12'd40, echo_amp: 8'd100, offset: '0, pings: 4'd3};
		rows[1] = '{echo_step: 12'd70, echo_amp: 8'd100, offset: '0, pings: 4'd3};
		rows[2] = '{echo_step: 12'd40, echo_amp: 8'd100,
			offset: {8'd0, 8'd0, 8'd0, 8'd16, 8'd0}, pings: 4'd5};
		rows[3] = '{echo_step: 12'd40, echo_amp: 8'd0, offset: '0, pings: 4'd0};
		rows[4] = '{echo_step: 12'd150, echo_amp: 8'd100, offset: '0, pings: 4'd3};
		apply_reset();
		for (int r = 0; r < NUM_ROWS; r++) begin
			start_measurement(r);
			waited = 0;
			if (rows[r].pings != 0) begin
				while (!delay_valid) begin
					if (waited == WAIT_LIMIT) begin
						fail_run($sformatf("row %0d timed out waiting for delay_valid", r));
					end else begin
						tick();
						waited++;
					end
				end
				check_value("ping_count", ping_count, cur.pings);
				check_value("agree_ping", agree_ping, ping_count);
				check_value("delay", delay, agree_delay);
				check_value("busy", busy, 0);
				held = delay;
				repeat (40) begin
					tick();
					check_value("delay_valid", delay_valid, 1);
					check_value("delay", delay, held);
				end
			end else begin
				while (ref_attempts < SILENT_PINGS) begin
					if (waited == WAIT_LIMIT) begin
						fail_run($sformatf("row %0d stopped pinging before six attempts", r));
					end else begin
						tick();
						waited++;
						check_value("delay_valid", delay_valid, 0);
					end
				end
				check_value("busy", busy, 1);
				apply_reset(); // the retry loop only ends with reset
			end
		end
		$display("All tests passed!");
		$finish;
	end

endmodule

`default_nettype wire

// ==== verilog/sos_ranger.sv ====
`timescale 1ns/10ps
`default_nettype none

module sos_ranger #(
	parameter int WINDOW_SIZE = sos_audio_pkg::WINDOW_SIZE_DEFAULT,
	parameter int MAX_DELAY = sos_ctrl_pkg::MAX_DELAY_DEFAULT,
	parameter int HOLDOFF_CYCLES = sos_ctrl_pkg::HOLDOFF_CYCLES_DEFAULT,
	parameter sos_audio_pkg::amp_t PULSE_AMP = sos_audio_pkg::PULSE_AMP_DEFAULT,
	parameter int PULSE_STEPS = sos_audio_pkg::PULSE_STEPS_DEFAULT
) (
	input wire clk_in,
	input wire rst_in,
	input wire step_in,  // one clock per sample
	input wire trigger,
	input wire sos_audio_pkg::sample_t mic_in,
	output sos_audio_pkg::amp_t amp_out,
	output sos_ctrl_pkg::delay_t delay, // in sample steps
	output logic delay_valid,
	output logic busy
);

	import sos_ctrl_pkg::*;

	logic fire;
	logic ping_done;
	logic listen_start;
	logic listen;
	logic window_done;
	logic onset;
	delay_t echo_count;
	logic echo_timeout;
	logic holdoff_start;
	logic holdoff_done;

	impulse_generator #(
		.PULSE_AMP(PULSE_AMP),
		.PULSE_STEPS(PULSE_STEPS)
	) impulse_generator_inst (
		.clk_in(clk_in),
		.rst_in(rst_in),
		.step_in(step_in),
		.fire(fire),
		.amp_out(amp_out),
		.ping_done(ping_done)
	);

	window_energy #(
		.WINDOW_SIZE(WINDOW_SIZE)
	) window_energy_inst (
		.clk_in(clk_in),
		.rst_in(rst_in),
		.step_in(step_in),
		.listen(listen),
		.listen_start(listen_start),
		.mic_in(mic_in),
		.window_done(window_done),
		.onset(onset)
	);

	echo_timer #(
		.MAX_DELAY(MAX_DELAY),
		.HOLDOFF_CYCLES(HOLDOFF_CYCLES)
	) echo_timer_inst (
		.clk_in(clk_in),
		.rst_in(rst_in),
		.step_in(step_in),
		.listen(listen),
		.listen_start(listen_start),
		.holdoff_start(holdoff_start),
		.echo_count(echo_count),
		.echo_timeout(echo_timeout),
		.holdoff_done(holdoff_done)
	);

	ranging_fsm ranging_fsm_inst (
		.clk_in(clk_in),
		.rst_in(rst_in),
		.trigger(trigger),
		.ping_done(ping_done),
		.window_done(window_done),
		.onset(onset),
		.echo_count(echo_count),
		.echo_timeout(echo_timeout),
		.holdoff_done(holdoff_done),
		.fire(fire),
		.listen_start(listen_start),
		.listen(listen),
		.holdoff_start(holdoff_start),
		.delay(delay),
		.delay_valid(delay_valid),
		.busy(busy)
	);

endmodule

`default_nettype wire

// ==== verilog/ranging_fsm.sv ====
`timescale 1ns/10ps
`default_nettype none

module ranging_fsm (
	input wire clk_in,
	input wire rst_in,
	input wire trigger,
	input wire ping_done,
	input wire window_done,
	input wire onset,
	input wire sos_ctrl_pkg::delay_t echo_count,
	input wire echo_timeout,
	input wire holdoff_done,
	output logic fire,
	output logic listen_start,
	output logic listen,
	output logic holdoff_start,
	output sos_ctrl_pkg::delay_t delay,
	output logic delay_valid,
	output logic busy
);

	import sos_ctrl_pkg::*;

	// past detections kept besides the current one
	localparam int HIST = AGREE_COUNT - 1;

	ranging_state_t state;
	delay_t hist [HIST]; // [0] is the most recent
	logic [HIST-1:0] hist_valid;
	logic agree;

	assign fire = (state == FIRE);
	assign listen = (state == LISTEN);

	// current detection matches every stored one
	always_comb begin
		agree = &hist_valid;
		for (int i = 0; i < HIST; i++) begin
			if (hist[i] != echo_count)
				agree = 1'b0;
		end
	end

	always_ff @(posedge clk_in) begin
		if (rst_in) begin
			state <= IDLE;
			listen_start <= 1'b0;
			holdoff_start <= 1'b0;
			hist_valid <= '0;
			delay <= '0;
			delay_valid <= 1'b0;
			busy <= 1'b0;
		end else begin
			listen_start <= 1'b0;
			holdoff_start <= 1'b0;
			case (state)
				IDLE: begin
					if (trigger) begin
						state <= FIRE;
						busy <= 1'b1;
						delay_valid <= 1'b0; // low for the whole FIRE clock
						hist_valid <= '0;    // fresh measurement
					end
				end
				FIRE: begin
					state <= AWAIT_PING;
				end
				AWAIT_PING: begin
					if (ping_done) begin
						state <= LISTEN;
						listen_start <= 1'b1;
					end
				end
				LISTEN: begin
					if (window_done && onset) begin
						if (agree) begin
							delay <= echo_count;
							delay_valid <= 1'b1;
							busy <= 1'b0;
							state <= IDLE;
						end else begin
							for (int i = HIST - 1; i > 0; i--)
								hist[i] <= hist[i-1];
							hist[0] <= echo_count;
							hist_valid <= HIST'({hist_valid, 1'b1});
							holdoff_start <= 1'b1;
							state <= HOLDOFF;
						end
					end else if (echo_timeout) begin
						// no echo, the run of equal delays is broken
						hist_valid <= '0;
						holdoff_start <= 1'b1;
						state <= HOLDOFF;
					end
				end
				HOLDOFF: begin
					if (holdoff_done)
						state <= FIRE;
				end
				default: begin
					state <= IDLE;
				end
			endcase
		end
	end

	// window_energy only flags an onset as a window closes
	assert property (@(posedge clk_in) disable iff (rst_in)
		(state == LISTEN && onset) |-> window_done)
		else $error("ranging_fsm: onset without window_done");

endmodule

`default_nettype wire

// ==== verilog/echo_timer.sv ====
`timescale 1ns/10ps
`default_nettype none

module echo_timer #(
	parameter int MAX_DELAY = sos_ctrl_pkg::MAX_DELAY_DEFAULT,
	parameter int HOLDOFF_CYCLES = sos_ctrl_pkg::HOLDOFF_CYCLES_DEFAULT
) (
	input wire clk_in,
	input wire rst_in,
	input wire step_in,
	input wire listen,
	input wire listen_start,
	input wire holdoff_start,
	output sos_ctrl_pkg::delay_t echo_count,
	output logic echo_timeout,
	output logic holdoff_done
);

	import sos_ctrl_pkg::*;

	localparam int HOLD_W = $clog2(HOLDOFF_CYCLES + 1);

	logic [HOLD_W-1:0] hold_cnt;
	logic holding;

	// steps since listening began
	always_ff @(posedge clk_in) begin
		if (rst_in) begin
			echo_count <= '0;
			echo_timeout <= 1'b0;
		end else begin
			echo_timeout <= 1'b0;
			if (listen_start) begin
				echo_count <= '0;
			end else if (listen && step_in) begin
				echo_count <= echo_count + 1'b1;
				if (echo_count == delay_t'(MAX_DELAY - 1))
					echo_timeout <= 1'b1; // lines up with echo_count == MAX_DELAY
			end
		end
	end

	// holdoff, counted in clocks
	always_ff @(posedge clk_in) begin
		if (rst_in) begin
			hold_cnt <= '0;
			holding <= 1'b0;
			holdoff_done <= 1'b0;
		end else begin
			holdoff_done <= 1'b0;
			if (holdoff_start) begin
				hold_cnt <= HOLD_W'(HOLDOFF_CYCLES - 1);
				holding <= 1'b1;
			end else if (holding) begin
				if (hold_cnt == '0) begin
					holding <= 1'b0;
					holdoff_done <= 1'b1; // HOLDOFF_CYCLES after the start strobe
				end else begin
					hold_cnt <= hold_cnt - 1'b1;
				end
			end
		end
	end

	assert property (@(posedge clk_in) disable iff (rst_in)
		holdoff_start |-> !holding)
		else $error("echo_timer: holdoff restarted while still counting");

endmodule

`default_nettype wire

// ==== verilog/window_energy.sv ====
`timescale 1ns/10ps
`default_nettype none

module window_energy #(
	parameter int WINDOW_SIZE = sos_audio_pkg::WINDOW_SIZE_DEFAULT
) (
	input wire clk_in,
	input wire rst_in,
	input wire step_in,
	input wire listen,
	input wire listen_start,
	input wire sos_audio_pkg::sample_t mic_in,
	output logic window_done,
	output logic onset
);

	import sos_audio_pkg::*;

	localparam int IDX_W = $clog2(WINDOW_SIZE + 1);
	localparam int CMP_W = $bits(energy_t) + 2; // room for 1.25x of an all-ones sum

	energy_t cur_sum;
	energy_t prev_sum;  // last window
	energy_t prev2_sum; // window before that
	energy_t next_sum;
	sample_t neg;
	logic [6:0] mag;
	logic [CMP_W-1:0] prev2_scaled;
	logic onset_hit;
	logic [IDX_W-1:0] idx;

	always_comb begin
		neg = -mic_in;
		if (mic_in == sample_t'(-128))
			mag = 7'h7f; // -128 has no positive twin
		else if (mic_in[7])
			mag = neg[6:0];
		else
			mag = mic_in[6:0];
		next_sum = cur_sum + energy_t'(mag); // includes this step's sample
		prev2_scaled = CMP_W'(prev2_sum) + CMP_W'(prev2_sum >> 2);
		onset_hit = (next_sum > prev_sum) && (CMP_W'(next_sum) > prev2_scaled);
	end

	always_ff @(posedge clk_in) begin
		if (rst_in) begin
			cur_sum <= '0;
			prev_sum <= '1;
			prev2_sum <= '1;
			idx <= '0;
			window_done <= 1'b0;
			onset <= 1'b0;
		end else begin
			window_done <= 1'b0;
			onset <= 1'b0;
			if (listen_start) begin
				// all ones keeps the first two windows from firing
				cur_sum <= '0;
				prev_sum <= '1;
				prev2_sum <= '1;
				idx <= '0;
			end else if (listen && step_in) begin
				if (idx == IDX_W'(WINDOW_SIZE - 1)) begin
					window_done <= 1'b1;
					idx <= '0;
					if (onset_hit) begin
						onset <= 1'b1;
						cur_sum <= next_sum; // attempt ends here, next listen_start clears
					end else begin
						prev2_sum <= prev_sum;
						prev_sum <= next_sum;
						cur_sum <= '0;
					end
				end else begin
					idx <= idx + 1'b1;
					cur_sum <= next_sum;
				end
			end
		end
	end

	// listen_start sits two clocks past the last ping step and after any window
	assert property (@(posedge clk_in) disable iff (rst_in)
		listen_start |-> !step_in && !window_done)
		else $error("window_energy: sample or window end lost to listen_start");

endmodule

`default_nettype wire

// ==== verilog/impulse_generator.sv ====
`timescale 1ns/10ps
`default_nettype none

module impulse_generator #(
	parameter sos_audio_pkg::amp_t PULSE_AMP = sos_audio_pkg::PULSE_AMP_DEFAULT,
	parameter int PULSE_STEPS = sos_audio_pkg::PULSE_STEPS_DEFAULT
) (
	input wire clk_in,
	input wire rst_in,
	input wire step_in,
	input wire fire,
	output sos_audio_pkg::amp_t amp_out,
	output logic ping_done
);

	localparam int CNT_W = $clog2(PULSE_STEPS + 1);

	logic pending; // fire seen, waiting for the next step
	logic active;  // pulse on the speaker
	logic [CNT_W-1:0] step_cnt;

	always_ff @(posedge clk_in) begin
		if (rst_in) begin
			pending <= 1'b0;
			active <= 1'b0;
			step_cnt <= '0;
			amp_out <= '0;
			ping_done <= 1'b0;
		end else begin
			ping_done <= 1'b0;
			if (fire) begin
				pending <= 1'b1; // a step in this same clock does not start it
			end else if (pending && step_in) begin
				pending <= 1'b0;
				active <= 1'b1;
				step_cnt <= '0;
				amp_out <= PULSE_AMP;
			end else if (active && step_in) begin
				// pulse stays up for PULSE_STEPS strobes after the start step
				if (step_cnt == CNT_W'(PULSE_STEPS - 1)) begin
					active <= 1'b0;
					amp_out <= '0;
					ping_done <= 1'b1;
				end else begin
					step_cnt <= step_cnt + 1'b1;
				end
			end
		end
	end

	// the FSM waits for ping_done, so a second fire here means it lost track
	assert property (@(posedge clk_in) disable iff (rst_in)
		fire |-> !(pending || active))
		else $error("impulse_generator: fire while a ping is in progress");

endmodule

`default_nettype wire

// ==== verilog/sos_ctrl_pkg.sv ====
`default_nettype none

package sos_ctrl_pkg;

	// delay in sample steps
	typedef logic [11:0] delay_t;

	// ranging sequence
	typedef enum logic [2:0] {
		IDLE,       // waiting for a trigger
		FIRE,       // one clock, kicks the ping
		AWAIT_PING, // speaker pulse still going
		LISTEN,     // windows running, steps counted
		HOLDOFF     // let the room go quiet before the next ping
	} ranging_state_t;

	// give up on an attempt after this many steps
	localparam int MAX_DELAY_DEFAULT = 512;

	// quiet time between pings, in clocks
	localparam int HOLDOFF_CYCLES_DEFAULT = 60_000_000;

	// attempts in a row that must give the same delay
	localparam int AGREE_COUNT = 3;

endpackage

`default_nettype wire

// ==== verilog/sos_audio_pkg.sv ====
`default_nettype none

package sos_audio_pkg;

	// one microphone sample, two's complement
	typedef logic signed [7:0] sample_t;

	// speaker drive word
	typedef logic signed [15:0] amp_t;

	// sum of |sample| over one window, plenty of headroom for long windows
	typedef logic [23:0] energy_t;

	// speaker level while a ping is on
	localparam amp_t PULSE_AMP_DEFAULT = 16'sd12000;

	// ping length in sample steps
	localparam int PULSE_STEPS_DEFAULT = 8;

	// samples per energy window, shorter gives less latency but coarser delay
	localparam int WINDOW_SIZE_DEFAULT = 16;

endpackage

`default_nettype wire
